// File: db_pkg.sv
`default_nettype none

package db_pkg;

    // Packet type codes
    localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
    localparam logic [3:0] FTYPE_NWRITE = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE = 4'h4;

    // Doorbell info codes
    localparam logic [15:0] DB_INFO_READY = 16'h0100;
    localparam logic [15:0] DB_INFO_BUSY = 16'h01FF;
    localparam logic [15:0] DB_INFO_SELF_CHECK = 16'h0101;
    localparam logic [15:0] DB_INFO_INTEG_BASE = 16'h0200;

    // Source ID carried by every valid target response
    localparam logic [15:0] TARGET_RESP_ID = 16'h00F0;

    // Region 1 starts at 1 MiB
    localparam logic [33:0] REGION_STRIDE = 34'h0_0010_0000;
    localparam logic [1:0] DB_PRIO = 2'h1;

    // Sizes
    localparam int TIMEOUT_CYCLES = 1024;
    localparam int TMO_W = $clog2(TIMEOUT_CYCLES);
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;
    localparam int TUSER_W = 32;

    typedef enum logic [2:0] {
        CS_IDLE    = 3'd0,
        CS_SC_REQ  = 3'd1,
        CS_SC_WAIT = 3'd2,
        CS_NW_HDR  = 3'd3,
        CS_NW_PAY  = 3'd4,
        CS_IN_REQ  = 3'd5,
        CS_IN_WAIT = 3'd6
    } ctrl_state_e;

    typedef enum logic [1:0] {
        BK_SC_DB   = 2'd0,
        BK_IN_DB   = 2'd1,
        BK_NW_HDR  = 2'd2,
        BK_PAYLOAD = 2'd3
    } beat_kind_e;

    typedef enum logic [1:0] {
        ERR_NONE      = 2'd0,
        ERR_SC_NORESP = 2'd1,
        ERR_IN_NORESP = 2'd2
    } err_type_e;

    // On the first beat data[7:0] is the byte count minus one
    typedef struct packed {
        logic              first;
        logic              last;
        logic [KEEP_W-1:0] keep;
        logic [DATA_W-1:0] data;
    } user_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0]  data;
        logic [KEEP_W-1:0]  keep;
        logic               last;
        logic [TUSER_W-1:0] tuser;
    } ireq_beat_t;

    typedef struct packed {
        logic        ready;
        logic        busy;
        logic        info_valid;
        logic [15:0] info;
    } resp_event_t;

    // Integrity doorbell info, 0x0201 for region 0 and 0x0200 for region 1
    function automatic logic [15:0] integ_info(input logic region);
        return DB_INFO_INTEG_BASE + {15'd0, ~region};
    endfunction

endpackage

`default_nettype wire

// File: user_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module user_fifo
    import db_pkg::*;
(
    input  wire              log_clk,
    input  wire              log_rst,

    input  wire              user_tvalid_i,
    input  wire              user_tfirst_i,
    input  wire              user_tlast_i,
    input  wire [KEEP_W-1:0] user_tkeep_i,
    input  wire [DATA_W-1:0] user_tdata_i,
    output logic             user_tready_o,

    output user_beat_t       beat_o,
    output logic             beat_valid_o,
    input  wire              beat_pop_i
);

    user_beat_t mem [FIFO_DEPTH];
    user_beat_t wr_beat;

    // One extra pointer bit tells full from empty
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic full;
    logic empty;
    logic do_wr;
    logic do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    assign do_wr = user_tvalid_i && !full;
    assign do_rd = beat_pop_i && !empty;

    assign wr_beat.first = user_tfirst_i;
    assign wr_beat.last = user_tlast_i;
    assign wr_beat.keep = user_tkeep_i;
    assign wr_beat.data = user_tdata_i;

    always_ff @(posedge log_clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry is visible in the same cycle
    assign beat_o = mem[rd_ptr[FIFO_AW-1:0]];
    assign beat_valid_o = !empty;

    // Stall the user while the buffer is full
    assign user_tready_o = !full;

endmodule

`default_nettype wire

// File: ireq_framer.sv
`timescale 1ns/1ps
`default_nettype none

module ireq_framer
    import db_pkg::*;
(
    input  wire         log_clk,
    input  wire         log_rst,

    input  beat_kind_e  kind_i,
    input  wire         frame_req_i,
    input  wire         region_i,
    input  wire [15:0]  src_id_i,
    input  wire [15:0]  des_id_i,

    input  user_beat_t  beat_i,
    input  wire         beat_valid_i,
    output logic        beat_pop_o,
    output logic        frame_done_o,

    output logic        ireq_tvalid_o,
    input  wire         ireq_tready_i,
    output ireq_beat_t  ireq_beat_o
);

    ireq_beat_t next_beat;
    logic [15:0] db_info;
    logic [33:0] hdr_addr;
    logic can_load;
    logic db_sel;
    logic hdr_sel;
    logic pay_sel;
    logic drop;
    logic load;
    logic load_end;
    // Held beat closes the current request
    logic out_end;
    // Final beat of the current request has been loaded
    logic issued;

    assign can_load = !ireq_tvalid_o || ireq_tready_i;

    assign db_info = (kind_i == BK_SC_DB) ? DB_INFO_SELF_CHECK : integ_info(region_i);
    assign hdr_addr = region_i ? REGION_STRIDE : 34'd0;

    always_comb begin
        db_sel = 1'b0;
        hdr_sel = 1'b0;
        pay_sel = 1'b0;
        drop = 1'b0;
        next_beat.data = beat_i.data;
        next_beat.keep = beat_i.keep;
        next_beat.last = beat_i.last;
        next_beat.tuser = {src_id_i, des_id_i};
        if (frame_req_i && !issued) begin
            case (kind_i)
                BK_SC_DB, BK_IN_DB: begin
                    db_sel = can_load;
                    next_beat.data = {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, DB_PRIO, 1'b0,
                                      12'h000, db_info, 16'h0000};
                    next_beat.keep = '1;
                    next_beat.last = 1'b1;
                end
                BK_NW_HDR: begin
                    // A stray non-first beat at the head is thrown away
                    hdr_sel = beat_valid_i && beat_i.first && can_load;
                    drop = beat_valid_i && !beat_i.first;
                    next_beat.data = {7'd0, region_i, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0,
                                      DB_PRIO, 1'b0, beat_i.data[7:0], 2'b00, hdr_addr};
                    next_beat.keep = '1;
                    next_beat.last = 1'b0;
                end
                default: begin
                    pay_sel = beat_valid_i && can_load;
                end
            endcase
        end
    end

    assign load = db_sel || hdr_sel || pay_sel;
    assign load_end = db_sel || hdr_sel || (pay_sel && beat_i.last);

    // Header consumes the first user beat
    assign beat_pop_o = hdr_sel || pay_sel || drop;
    assign frame_done_o = ireq_tvalid_o && ireq_tready_i && out_end;

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            ireq_tvalid_o <= 1'b0;
            out_end <= 1'b0;
            issued <= 1'b0;
        end else begin
            if (load) begin
                ireq_tvalid_o <= 1'b1;
                out_end <= load_end;
            end else if (ireq_tready_i) begin
                ireq_tvalid_o <= 1'b0;
                out_end <= 1'b0;
            end
            if (frame_done_o) begin
                issued <= 1'b0;
            end else if (load_end) begin
                issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge log_clk) begin
        if (load) begin
            ireq_beat_o <= next_beat;
        end
    end

endmodule

`default_nettype wire

// File: resp_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module resp_monitor
    import db_pkg::*;
(
    input  wire               log_clk,
    input  wire               log_rst,

    input  wire               iresp_tvalid_i,
    input  wire [DATA_W-1:0]  iresp_tdata_i,
    input  wire [TUSER_W-1:0] iresp_tuser_i,

    input  wire               wait_i,
    output resp_event_t       event_o,
    output logic              timeout_o
);

    logic [3:0] resp_ftype;
    logic [15:0] resp_info;
    logic [15:0] resp_src_id;
    logic match;
    logic ready_q;
    logic busy_q;
    logic info_valid_q;
    logic [15:0] info_q;
    logic [TMO_W-1:0] tmo_cnt;

    // Response header fields
    assign resp_ftype = iresp_tdata_i[55:52];
    assign resp_info = iresp_tdata_i[31:16];
    assign resp_src_id = iresp_tuser_i[31:16];

    // Only doorbells from the target count
    assign match = iresp_tvalid_i && (resp_ftype == FTYPE_DOORBELL) &&
                   (resp_src_id == TARGET_RESP_ID);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            ready_q <= 1'b0;
            busy_q <= 1'b0;
            info_valid_q <= 1'b0;
        end else begin
            ready_q <= match && (resp_info == DB_INFO_READY);
            busy_q <= match && (resp_info == DB_INFO_BUSY);
            info_valid_q <= match;
        end
    end

    always_ff @(posedge log_clk) begin
        info_q <= resp_info;
    end

    assign event_o.ready = ready_q;
    assign event_o.busy = busy_q;
    assign event_o.info_valid = info_valid_q;
    assign event_o.info = info_q;

    // Counts wait cycles, cleared whenever the wait ends
    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            tmo_cnt <= '0;
        end else if (wait_i) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end else begin
            tmo_cnt <= '0;
        end
    end

    assign timeout_o = wait_i && (tmo_cnt == TMO_W'(TIMEOUT_CYCLES - 1));

endmodule

`default_nettype wire

// File: db_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module db_req_ctrl
    import db_pkg::*;
(
    input  wire          log_clk,
    input  wire          log_rst,

    input  wire          self_check_i,
    input  wire          nwr_req_i,
    input  wire          link_up_i,

    input  resp_event_t  event_i,
    input  wire          timeout_i,

    output beat_kind_e   kind_o,
    output logic         frame_req_o,
    input  wire          frame_done_i,
    output logic         region_o,
    output logic         wait_o,

    output logic         nwr_ready_o,
    output logic         nwr_busy_o,
    output logic         nwr_done_ack_o,
    output logic         error_o,
    output err_type_e    error_type_o
);

    ctrl_state_e state;
    ctrl_state_e state_nx;
    logic start_sc;
    logic start_nw;
    logic integ_ok;

    // Self-check wins over a write request
    assign start_sc = link_up_i && self_check_i;
    assign start_nw = link_up_i && nwr_req_i && !self_check_i;

    assign integ_ok = event_i.info_valid && (event_i.info == integ_info(region_o));

    always_comb begin
        state_nx = state;
        case (state)
            CS_IDLE: begin
                if (start_sc) begin
                    state_nx = CS_SC_REQ;
                end else if (start_nw) begin
                    state_nx = CS_NW_HDR;
                end
            end
            CS_SC_REQ: begin
                if (frame_done_i) begin
                    state_nx = CS_SC_WAIT;
                end
            end
            CS_SC_WAIT: begin
                if (event_i.ready || event_i.busy || timeout_i) begin
                    state_nx = CS_IDLE;
                end
            end
            CS_NW_HDR: begin
                if (frame_done_i) begin
                    state_nx = CS_NW_PAY;
                end
            end
            CS_NW_PAY: begin
                // Done only after the user-last beat
                if (frame_done_i) begin
                    state_nx = CS_IN_REQ;
                end
            end
            CS_IN_REQ: begin
                if (frame_done_i) begin
                    state_nx = CS_IN_WAIT;
                end
            end
            CS_IN_WAIT: begin
                if (integ_ok || timeout_i) begin
                    state_nx = CS_IDLE;
                end
            end
            default: begin
                state_nx = CS_IDLE;
            end
        endcase
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            state <= CS_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        case (state)
            CS_IN_REQ: kind_o = BK_IN_DB;
            CS_NW_HDR: kind_o = BK_NW_HDR;
            CS_NW_PAY: kind_o = BK_PAYLOAD;
            default:   kind_o = BK_SC_DB;
        endcase
    end

    assign frame_req_o = (state == CS_SC_REQ) || (state == CS_NW_HDR) ||
                         (state == CS_NW_PAY) || (state == CS_IN_REQ);
    assign wait_o = (state == CS_SC_WAIT) || (state == CS_IN_WAIT);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            nwr_ready_o <= 1'b0;
            nwr_busy_o <= 1'b0;
            nwr_done_ack_o <= 1'b0;
            error_o <= 1'b0;
            error_type_o <= ERR_NONE;
            region_o <= 1'b0;
        end else begin
            nwr_done_ack_o <= 1'b0;
            error_o <= 1'b0;
            error_type_o <= ERR_NONE;
            case (state)
                CS_IDLE: begin
                    // Status is held until the next self-check
                    if (start_sc) begin
                        nwr_ready_o <= 1'b0;
                        nwr_busy_o <= 1'b0;
                    end
                end
                CS_SC_WAIT: begin
                    if (event_i.ready) begin
                        nwr_ready_o <= 1'b1;
                        nwr_busy_o <= 1'b0;
                    end else if (event_i.busy) begin
                        nwr_ready_o <= 1'b0;
                        nwr_busy_o <= 1'b1;
                    end else if (timeout_i) begin
                        error_o <= 1'b1;
                        error_type_o <= ERR_SC_NORESP;
                    end
                end
                CS_IN_WAIT: begin
                    if (integ_ok) begin
                        region_o <= ~region_o;
                        nwr_done_ack_o <= 1'b1;
                    end else if (timeout_i) begin
                        error_o <= 1'b1;
                        error_type_o <= ERR_IN_NORESP;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: db_req_top.sv
`timescale 1ns/1ps
`default_nettype none

module db_req_top
    import db_pkg::*;
(
    input  wire               log_clk,
    input  wire               log_rst,

    input  wire [15:0]        src_id_i,
    input  wire [15:0]        des_id_i,

    input  wire               self_check_i,
    input  wire               nwr_req_i,
    input  wire               link_up_i,
    output logic              nwr_ready_o,
    output logic              nwr_busy_o,
    output logic              nwr_done_ack_o,
    output logic              error_o,
    output err_type_e         error_type_o,

    input  wire               user_tvalid_i,
    output logic              user_tready_o,
    input  wire               user_tfirst_i,
    input  wire               user_tlast_i,
    input  wire [KEEP_W-1:0]  user_tkeep_i,
    input  wire [DATA_W-1:0]  user_tdata_i,

    output logic              ireq_tvalid_o,
    input  wire               ireq_tready_i,
    output ireq_beat_t        ireq_beat_o,

    input  wire               iresp_tvalid_i,
    input  wire [DATA_W-1:0]  iresp_tdata_i,
    input  wire [TUSER_W-1:0] iresp_tuser_i
);

    user_beat_t fifo_beat;
    logic fifo_valid;
    logic fifo_pop;
    beat_kind_e kind;
    logic frame_req;
    logic frame_done;
    logic region;
    logic resp_wait;
    resp_event_t resp_evt;
    logic timeout;

    user_fifo u_user_fifo (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .user_tvalid_i (user_tvalid_i),
        .user_tfirst_i (user_tfirst_i),
        .user_tlast_i  (user_tlast_i),
        .user_tkeep_i  (user_tkeep_i),
        .user_tdata_i  (user_tdata_i),
        .user_tready_o (user_tready_o),
        .beat_o        (fifo_beat),
        .beat_valid_o  (fifo_valid),
        .beat_pop_i    (fifo_pop)
    );

    ireq_framer u_ireq_framer (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .kind_i        (kind),
        .frame_req_i   (frame_req),
        .region_i      (region),
        .src_id_i      (src_id_i),
        .des_id_i      (des_id_i),
        .beat_i        (fifo_beat),
        .beat_valid_i  (fifo_valid),
        .beat_pop_o    (fifo_pop),
        .frame_done_o  (frame_done),
        .ireq_tvalid_o (ireq_tvalid_o),
        .ireq_tready_i (ireq_tready_i),
        .ireq_beat_o   (ireq_beat_o)
    );

    resp_monitor u_resp_monitor (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .wait_i         (resp_wait),
        .event_o        (resp_evt),
        .timeout_o      (timeout)
    );

    db_req_ctrl u_db_req_ctrl (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .self_check_i   (self_check_i),
        .nwr_req_i      (nwr_req_i),
        .link_up_i      (link_up_i),
        .event_i        (resp_evt),
        .timeout_i      (timeout),
        .kind_o         (kind),
        .frame_req_o    (frame_req),
        .frame_done_i   (frame_done),
        .region_o       (region),
        .wait_o         (resp_wait),
        .nwr_ready_o    (nwr_ready_o),
        .nwr_busy_o     (nwr_busy_o),
        .nwr_done_ack_o (nwr_done_ack_o),
        .error_o        (error_o),
        .error_type_o   (error_type_o)
    );

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import db_pkg::*;
(
    input  wire        log_clk,
    input  wire        log_rst,

    input  wire        req_valid_i,
    input  wire        req_ready_i,
    input  ireq_beat_t req_beat_i,

    input  wire        done_ack_i,
    input  wire        error_i,
    input  err_type_e  error_type_i
);

    ireq_beat_t exp_q[$];
    ireq_beat_t exp_beat;
    ireq_beat_t held_beat;
    logic held = 1'b0;
    logic ack_armed = 1'b0;
    logic err_armed = 1'b0;
    err_type_e exp_err = ERR_NONE;

    int value_errs = 0;
    int other_errs = 0;
    int accept_cnt = 0;
    int ack_cnt = 0;
    int err_cnt = 0;
    longint cycle = 0;
    longint last_accept = 0;

    task automatic push_expected(input ireq_beat_t beat);
        exp_q.push_back(beat);
    endtask

    task automatic expect_ack();
        ack_armed = 1'b1;
    endtask

    task automatic expect_error(input err_type_e kind);
        err_armed = 1'b1;
        exp_err = kind;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        other_errs++;
    endtask

    // Anything still pending at the end was never seen
    task automatic final_check();
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected request beats never arrived", exp_q.size()));
        end
        if (ack_armed || err_armed) begin
            report_failure("an expected status pulse never arrived");
        end
    endtask

    always @(posedge log_clk) begin
        if (!log_rst) begin
            cycle++;
            // A stalled beat must stay valid and unchanged
            if (held && !req_valid_i) begin
                report_failure("ireq_tvalid_o dropped before the beat was accepted");
            end else if (held && (req_beat_i !== held_beat)) begin
                report_failure("ireq_beat_o changed while stalled by ireq_tready_i");
            end
            if (req_valid_i && req_ready_i) begin
                accept_cnt++;
                last_accept = cycle;
                if (exp_q.size() == 0) begin
                    report_failure("request beat accepted while none was expected");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("ireq_beat_o.data", req_beat_i.data, exp_beat.data);
                    check_value("ireq_beat_o.keep", req_beat_i.keep, exp_beat.keep);
                    check_value("ireq_beat_o.last", req_beat_i.last, exp_beat.last);
                    check_value("ireq_beat_o.tuser", req_beat_i.tuser, exp_beat.tuser);
                end
            end
            held = req_valid_i && !req_ready_i;
            held_beat = req_beat_i;

            if (done_ack_i) begin
                ack_cnt++;
                if (!ack_armed) begin
                    report_failure("nwr_done_ack_o pulsed without a confirmed write");
                end
                ack_armed = 1'b0;
            end
            if (error_i) begin
                err_cnt++;
                if (!err_armed) begin
                    report_failure("error_o pulsed while no timeout was due");
                end else begin
                    check_value("error_type_o", error_type_i, exp_err);
                    // Rises TIMEOUT_CYCLES edges after the accept, seen one sample later
                    check_value("error_o delay", cycle - last_accept, TIMEOUT_CYCLES + 1);
                end
                err_armed = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_db_req.sv
`timescale 1ns/1ps
`default_nettype none

module tb_db_req
    import db_pkg::*;
;

    localparam logic [31:0] SEED = 32'h5724;
    localparam int NUM_TESTS = 14;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (TIMEOUT_CYCLES + 600);
    localparam logic [15:0] SRC_ID = 16'h0012;
    localparam logic [15:0] DES_ID = 16'h0034;

    logic log_clk;
    logic log_rst;
    logic self_check_i;
    logic nwr_req_i;
    logic link_up_i;
    logic nwr_ready_o;
    logic nwr_busy_o;
    logic nwr_done_ack_o;
    logic error_o;
    err_type_e error_type_o;
    logic user_tvalid_i;
    logic user_tready_o;
    logic user_tfirst_i;
    logic user_tlast_i;
    logic [KEEP_W-1:0] user_tkeep_i;
    logic [DATA_W-1:0] user_tdata_i;
    logic ireq_tvalid_o;
    logic ireq_tready_i;
    ireq_beat_t ireq_beat_o;
    logic iresp_tvalid_i;
    logic [DATA_W-1:0] iresp_tdata_i;
    logic [TUSER_W-1:0] iresp_tuser_i;

    logic [31:0] rng_state;
    logic [31:0] bp_state;
    logic exp_region;
    user_beat_t user_q[$];

    db_req_top uut (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .src_id_i       (SRC_ID),
        .des_id_i       (DES_ID),
        .self_check_i   (self_check_i),
        .nwr_req_i      (nwr_req_i),
        .link_up_i      (link_up_i),
        .nwr_ready_o    (nwr_ready_o),
        .nwr_busy_o     (nwr_busy_o),
        .nwr_done_ack_o (nwr_done_ack_o),
        .error_o        (error_o),
        .error_type_o   (error_type_o),
        .user_tvalid_i  (user_tvalid_i),
        .user_tready_o  (user_tready_o),
        .user_tfirst_i  (user_tfirst_i),
        .user_tlast_i   (user_tlast_i),
        .user_tkeep_i   (user_tkeep_i),
        .user_tdata_i   (user_tdata_i),
        .ireq_tvalid_o  (ireq_tvalid_o),
        .ireq_tready_i  (ireq_tready_i),
        .ireq_beat_o    (ireq_beat_o),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i)
    );

    tb_checker chk (
        .log_clk      (log_clk),
        .log_rst      (log_rst),
        .req_valid_i  (ireq_tvalid_o),
        .req_ready_i  (ireq_tready_i),
        .req_beat_i   (ireq_beat_o),
        .done_ack_i   (nwr_done_ack_o),
        .error_i      (error_o),
        .error_type_i (error_type_o)
    );

    initial begin
        log_clk = 1'b0;
        forever #10 log_clk = ~log_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Only the upper half is used since the low LCG bits repeat too quickly
    function automatic logic [15:0] rand16();
        rng_state = lcg_next(rng_state);
        return rng_state[31:16];
    endfunction

    // HELLO header layout with tid, ftype, ttype, prio, size and a 34-bit address
    function automatic logic [63:0] pack_header(input logic [7:0] tid, input logic [3:0] ftype,
                                                input logic [3:0] ttype, input logic [7:0] size,
                                                input logic [33:0] addr);
        return {tid, ftype, ttype, 1'b0, DB_PRIO, 1'b0, size, 2'b00, addr};
    endfunction

    function automatic logic [63:0] doorbell_header(input logic [15:0] info);
        return pack_header(8'h00, FTYPE_DOORBELL, 4'h0, 8'h00, {2'b00, info, 16'h0000});
    endfunction

    function automatic ireq_beat_t make_req_beat(input logic [63:0] data, input logic [7:0] keep,
                                                 input logic last);
        ireq_beat_t b;
        b.data = data;
        b.keep = keep;
        b.last = last;
        b.tuser = {SRC_ID, DES_ID};
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge log_clk);
        #2;
    endtask

    task automatic send_response(input logic [15:0] info);
        iresp_tvalid_i = 1'b1;
        iresp_tdata_i = doorbell_header(info);
        iresp_tuser_i = {TARGET_RESP_ID, SRC_ID};
        next_cycle();
        iresp_tvalid_i = 1'b0;
    endtask

    // Drains user_q into the user stream with random idle gaps
    task automatic feed_packet();
        user_beat_t ub;
        logic ok;
        while (user_q.size() > 0) begin
            if (rand16() % 4 == 0) begin
                user_tvalid_i = 1'b0;
                next_cycle();
            end
            ub = user_q.pop_front();
            user_tvalid_i = 1'b1;
            user_tfirst_i = ub.first;
            user_tlast_i = ub.last;
            user_tkeep_i = ub.keep;
            user_tdata_i = ub.data;
            do begin
                ok = user_tready_o;
                // At most one packet sits in the FIFO so it never fills
                chk.check_value("user_tready_o", user_tready_o, 1);
                next_cycle();
            end while (!ok);
        end
        user_tvalid_i = 1'b0;
    endtask

    // Answer 0 asks for ready, 1 for busy and 2 for no answer
    task automatic run_self_check(input int answer);
        int base;
        int errs;
        base = chk.accept_cnt;
        chk.push_expected(make_req_beat(doorbell_header(DB_INFO_SELF_CHECK), 8'hFF, 1'b1));
        self_check_i = 1'b1;
        next_cycle();
        self_check_i = 1'b0;
        next_cycle();
        chk.check_value("ireq_tvalid_o", ireq_tvalid_o, 1);
        while (chk.accept_cnt == base) next_cycle();
        if (answer == 2) begin
            errs = chk.err_cnt;
            chk.expect_error(ERR_SC_NORESP);
            while (chk.err_cnt == errs) next_cycle();
        end else begin
            repeat (1 + rand16() % 48) next_cycle();
            send_response((answer == 0) ? DB_INFO_READY : DB_INFO_BUSY);
            while (!(nwr_ready_o || nwr_busy_o)) next_cycle();
        end
        chk.check_value("nwr_ready_o", nwr_ready_o, answer == 0);
        chk.check_value("nwr_busy_o", nwr_busy_o, answer == 1);
    endtask

    task automatic run_write(input logic confirm);
        int nbeats;
        int nbytes;
        int base;
        int cnt;
        logic [7:0] last_keep;
        logic [15:0] info;
        user_beat_t ub;
        nbeats = 1 + rand16() % 16;
        nbytes = (nbeats - 1) * 8 + 1 + rand16() % 8;
        last_keep = 8'hFF << (nbeats * 8 - nbytes);
        info = exp_region ? 16'h0200 : 16'h0201;

        // First user beat only carries the size
        ub.first = 1'b1;
        ub.last = 1'b0;
        ub.keep = 8'hFF;
        ub.data = {rand16(), rand16(), rand16(), rand16()};
        ub.data[7:0] = 8'(nbytes - 1);
        user_q.push_back(ub);
        chk.push_expected(make_req_beat(pack_header({7'd0, exp_region}, FTYPE_NWRITE,
            TTYPE_NWRITE, ub.data[7:0], exp_region ? REGION_STRIDE : 34'd0), 8'hFF, 1'b0));
        for (int i = 0; i < nbeats; i++) begin
            ub.first = 1'b0;
            ub.last = (i == nbeats - 1);
            ub.keep = ub.last ? last_keep : 8'hFF;
            ub.data = {rand16(), rand16(), rand16(), rand16()};
            user_q.push_back(ub);
            chk.push_expected(make_req_beat(ub.data, ub.keep, ub.last));
        end
        chk.push_expected(make_req_beat(doorbell_header(info), 8'hFF, 1'b1));

        base = chk.accept_cnt;
        fork
            feed_packet();
            begin
                nwr_req_i = 1'b1;
                next_cycle();
                nwr_req_i = 1'b0;
                while (chk.accept_cnt < base + nbeats + 2) next_cycle();
            end
        join

        if (confirm) begin
            repeat (1 + rand16() % 48) next_cycle();
            cnt = chk.ack_cnt;
            chk.expect_ack();
            send_response(info);
            while (chk.ack_cnt == cnt) next_cycle();
            exp_region = ~exp_region;
        end else begin
            cnt = chk.err_cnt;
            chk.expect_error(ERR_IN_NORESP);
            while (chk.err_cnt == cnt) next_cycle();
        end
    endtask

    // Random back-pressure from its own LCG stream
    initial begin
        wait (log_rst === 1'b0);
        forever begin
            bp_state = lcg_next(bp_state);
            ireq_tready_i = (bp_state[31:30] != 2'b00);
            next_cycle();
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge log_clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Summary: %0d value errors, %0d other errors", chk.value_errs, chk.other_errs);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rng_state = SEED;
        log_rst = 1'b1;
        link_up_i = 1'b0;
        self_check_i = 1'b0;
        nwr_req_i = 1'b0;
        user_tvalid_i = 1'b0;
        user_tfirst_i = 1'b0;
        user_tlast_i = 1'b0;
        user_tkeep_i = '0;
        user_tdata_i = '0;
        ireq_tready_i = 1'b0;
        iresp_tvalid_i = 1'b0;
        iresp_tdata_i = '0;
        iresp_tuser_i = '0;
        exp_region = 1'b0;
        bp_state = {rand16(), rand16()};
        repeat (10) next_cycle();
        log_rst = 1'b0;
        link_up_i = 1'b1;
        next_cycle();

        chk.check_value("ireq_tvalid_o", ireq_tvalid_o, 0);
        chk.check_value("nwr_ready_o", nwr_ready_o, 0);
        chk.check_value("nwr_busy_o", nwr_busy_o, 0);
        chk.check_value("error_o", error_o, 0);
        chk.check_value("nwr_done_ack_o", nwr_done_ack_o, 0);
        chk.check_value("region", uut.region, 0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            if (t < 3) begin
                run_self_check(t);
            end else if (t > 4 && rand16() % 6 == 0) begin
                run_self_check(rand16() % 3);
            end else begin
                // Test 4 always leaves the integrity doorbell unanswered
                run_write((t != 4) && (rand16() % 4 != 0));
            end
            repeat (2) next_cycle();
        end

        chk.final_check();
        $display("Summary: %0d value errors, %0d other errors", chk.value_errs, chk.other_errs);
        if (chk.value_errs == 0 && chk.other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
db_pkg.sv
user_fifo.sv
ireq_framer.sv
resp_monitor.sv
db_req_ctrl.sv
db_req_top.sv
tb_checker.sv
tb_db_req.sv
